/* arbiter/age_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_share_defs.svh"

module age_arbiter
  import mem_share_pkg::*;
(
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire [`MS_NUM_CLIENTS-1:0]              req,
  input  wire [`MS_NUM_CLIENTS-1:0]              we,
  input  wire mem_addr_t [`MS_NUM_CLIENTS-1:0]   addr,
  input  wire mem_data_t [`MS_NUM_CLIENTS-1:0]   wdata,
  output logic [`MS_NUM_CLIENTS-1:0]             ack,
  output mem_data_t [`MS_NUM_CLIENTS-1:0]        rdata,
  ram_if.master                                  ram
);

  localparam int NUM   = `MS_NUM_CLIENTS;
  localparam int KEY_W = $bits(arb_key_t);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_ACCESS   = 2'd1;
  localparam logic [1:0] ST_WAIT_REL = 2'd2;

  logic [1:0]             state;
  client_id_t             grant;
  logic                   busy;
  age_t                   age [NUM];
  logic [NUM*KEY_W-1:0]   keys;
  arb_key_t               win_key;
  client_id_t             win_id;
  logic                   win_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Winner selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < NUM; i++) begin : g_key
    assign keys[i*KEY_W +: KEY_W] = {req[i], age[i]};
  end

  max_finder_tree #(
    .PORT_COUNT (NUM),
    .DATA_WIDTH (KEY_W)
  ) u_tree (
    .values  (keys),
    .max_val (win_key),
    .max_ptr (win_id)
  );

  // Top key bit set means somebody is asking
  assign win_valid = win_key[KEY_W-1];

  // A grant is live from registration until ack drops
  assign busy = (state != ST_IDLE);

  // Saturating ages
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM; i++) begin
        age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM; i++) begin
        if (!busy && win_valid && (win_id == client_id_t'(i))) begin
          age[i] <= '0;
        end else if (req[i] && !(busy && (grant == client_id_t'(i)))) begin
          if (age[i] != '1) begin
            age[i] <= age[i] + 1'b1;
          end
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      grant <= '0;
      ack   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (win_valid) begin
            grant <= win_id;
            state <= ST_ACCESS;
          end
        end
        // RAM does the access at this edge
        ST_ACCESS: state <= ST_WAIT_REL;
        ST_WAIT_REL: begin
          if (!ack[grant]) begin
            ack[grant] <= 1'b1;
          end else if (!req[grant]) begin
            ack[grant] <= 1'b0;
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Read data lands with the rising ack
  always_ff @(posedge clk) begin
    if ((state == ST_WAIT_REL) && !ack[grant] && !we[grant]) begin
      rdata[grant] <= ram.rdata;
    end
  end

  // RAM access from the granted client
  assign ram.en    = (state == ST_ACCESS);
  assign ram.we    = we[grant];
  assign ram.addr  = addr[grant];
  assign ram.wdata = wdata[grant];

endmodule

`default_nettype wire

/* arbiter/max_finder_tree.sv */
`timescale 1ns/100ps
`default_nettype none

module max_finder_tree #(
  parameter int PORT_COUNT = 16,
  parameter int DATA_WIDTH = 8
) (
  input  wire [PORT_COUNT*DATA_WIDTH-1:0] values,
  output wire [DATA_WIDTH-1:0]            max_val,
  output wire [$clog2(PORT_COUNT)-1:0]    max_ptr
);

  localparam int ADDR_WIDTH = $clog2(PORT_COUNT);
  localparam int NODE_COUNT = 2 * PORT_COUNT - 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Heap numbered nodes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Node 1 is the root, node n has children 2n and 2n+1,
  // leaves sit at PORT_COUNT .. 2*PORT_COUNT-1
  logic [DATA_WIDTH-1:0] node_val [1:NODE_COUNT];
  logic [ADDR_WIDTH-1:0] node_ptr [1:NODE_COUNT];

  genvar k;
  genvar n;

  generate
    for (k = 0; k < PORT_COUNT; k = k + 1) begin : g_leaf
      assign node_val[PORT_COUNT+k] = values[k*DATA_WIDTH +: DATA_WIDTH];
      // Path bits get prepended on the way up
      assign node_ptr[PORT_COUNT+k] = '0;
    end

    for (n = 1; n < PORT_COUNT; n = n + 1) begin : g_node
      // Height above the leaves, root is ADDR_WIDTH
      localparam int HEIGHT = ADDR_WIDTH - $clog2(n + 1) + 1;
      localparam logic [ADDR_WIDTH-1:0] PATH_BIT = 1 << (HEIGHT - 1);

      logic right_wins;

      // Strict compare keeps ties on the lower index
      assign right_wins = node_val[2*n+1] > node_val[2*n];

      assign node_val[n] = right_wins ? node_val[2*n+1] : node_val[2*n];

      assign node_ptr[n] = right_wins ? (node_ptr[2*n+1] | PATH_BIT)
                                      : node_ptr[2*n];
    end
  endgenerate

  assign max_val = node_val[1];
  assign max_ptr = node_ptr[1];

endmodule

`default_nettype wire

/* common/mem_share_defs.svh */
`ifndef MEM_SHARE_DEFS_SVH
`define MEM_SHARE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared memory subsystem sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Peer clients, must stay a power of two for the max tree
`define MS_NUM_CLIENTS 4

// Waiting age counter, saturates at all ones
`define MS_AGE_WIDTH 6

// 64 word RAM
`define MS_ADDR_WIDTH 6
`define MS_DATA_WIDTH 16

`endif

/* common/mem_share_pkg.sv */
`default_nettype none

`include "mem_share_defs.svh"

package mem_share_pkg;

  // Index of one client
  typedef logic [$clog2(`MS_NUM_CLIENTS)-1:0] client_id_t;

  // How long a pending request has waited
  typedef logic [`MS_AGE_WIDTH-1:0] age_t;

  // Request bit on top, age below
  typedef logic [`MS_AGE_WIDTH:0] arb_key_t;

  // RAM word address and word
  typedef logic [`MS_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`MS_DATA_WIDTH-1:0] mem_data_t;

endpackage

`default_nettype wire

/* common/ram_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface ram_if
  import mem_share_pkg::*;
();

  logic      en;
  logic      we;
  mem_addr_t addr;
  mem_data_t wdata;
  mem_data_t rdata;

  // Arbiter side
  modport master (
    output en,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  // RAM side
  modport slave (
    input  en,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* tb/mem_share_assert.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_share_defs.svh"

module mem_share_assert (
  input wire                       clk,
  input wire                       rst,
  input wire [`MS_NUM_CLIENTS-1:0] req,
  input wire [`MS_NUM_CLIENTS-1:0] ack,
  input wire                       en
);

  // Failed assertions so far
  int failures = 0;

  // Only the granted client is ever acknowledged
  ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
    else begin
      $error("More than one ack is high");
      failures++;
    end

  // One RAM access per grant
  en_single: assert property (@(posedge clk) disable iff (rst) en |=> !en)
    else begin
      $error("RAM enable held longer than one cycle");
      failures++;
    end

  for (genvar i = 0; i < `MS_NUM_CLIENTS; i++) begin : g_client
    ack_release: assert property (@(posedge clk) disable iff (rst)
      $fell(ack[i]) |-> !$past(req[i]))
      else begin
        $error("ack %0d dropped while its req was still high", i);
        failures++;
      end
  end

endmodule

bind age_arbiter mem_share_assert assert_i (
  .clk (clk),
  .rst (rst),
  .req (req),
  .ack (ack),
  .en  (ram.en)
);

`default_nettype wire

/* tb/mem_share_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_share_defs.svh"

module mem_share_tb
  import mem_share_pkg::*;
();

  localparam int NUM = `MS_NUM_CLIENTS;
  localparam int AW  = `MS_ADDR_WIDTH;
  localparam int DW  = `MS_DATA_WIDTH;
  // req seen at the first edge, ack two edges later, sampled on the falling edge
  localparam int ACK_LATENCY = 3;
  // About four times the length of all tests together
  localparam int TIMEOUT_CYCLES = 2000;

  logic              clk;
  logic              rst;
  logic [NUM-1:0]    req;
  logic [NUM-1:0]    we;
  logic [NUM*AW-1:0] addr;
  logic [NUM*DW-1:0] wdata;
  wire  [NUM-1:0]    ack;
  wire  [NUM*DW-1:0] rdata;

  logic [31:0]    lfsr_state;
  logic [NUM-1:0] ack_prev;
  int             cycle_count;
  int             data_errors;
  int             order_errors;
  int             ctrl_errors;
  int             assert_errors;
  client_id_t     ack_order [$];
  mem_addr_t      written [$];
  mem_data_t      model [2**AW];

  mem_share_top dut_i (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles with tests still running", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Grant order as seen by rising acks
  always @(negedge clk) begin
    for (int i = 0; i < NUM; i++) begin
      if (ack[i] && !ack_prev[i]) begin
        ack_order.push_back(client_id_t'(i));
      end
    end
    ack_prev = ack;
  end

  // Taps 32,22,2,1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_data(input mem_data_t exp, input mem_data_t act, input string what);
    if (act !== exp) begin
      data_errors++;
      $display("FAIL %0t: %s expected %h, got %h", $time, what, exp, act);
    end
  endtask

  task automatic check_client(input client_id_t exp, input client_id_t act);
    if (act !== exp) begin
      order_errors++;
      $display("FAIL %0t: grant order expected client %0d, got %0d", $time, exp, act);
    end
  endtask

  task automatic check_cycles(input int exp, input int act, input string what);
    if (act != exp) begin
      ctrl_errors++;
      $display("FAIL %0t: %s expected %0d cycles, got %0d", $time, what, exp, act);
    end
  endtask

  task automatic check_acks(input logic [NUM-1:0] exp, input logic [NUM-1:0] act);
    if (act !== exp) begin
      ctrl_errors++;
      $display("FAIL %0t: ack vector expected %b, got %b", $time, exp, act);
    end
  endtask

  task automatic expect_grant(input client_id_t exp);
    if (ack_order.size() == 0) begin
      order_errors++;
      $display("Client %0d was never acknowledged (time %0t)", exp, $time);
    end else begin
      check_client(exp, ack_order.pop_front());
    end
  endtask

  task automatic expect_no_more_grants();
    if (ack_order.size() != 0) begin
      order_errors++;
      $display("Unexpected extra grant to client %0d", ack_order[0]);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Client side four-phase helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic start_access(input int c, input logic w, input mem_addr_t a,
                              input mem_data_t d);
    @(negedge clk);
    we[c] = w;
    addr[c*AW +: AW] = a;
    wdata[c*DW +: DW] = d;
    req[c] = 1'b1;
  endtask

  task automatic wait_ack(input int c, output int waited);
    waited = 0;
    while (!ack[c]) begin
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic release_req(input int c);
    req[c] = 1'b0;
    @(negedge clk);
    while (ack[c]) @(negedge clk);
  endtask

  task automatic write_word(input int c, input mem_addr_t a, input mem_data_t d);
    int waited;
    start_access(c, 1'b1, a, d);
    wait_ack(c, waited);
    // Contention only ever adds to the uncontended latency
    if (waited < ACK_LATENCY) begin
      check_cycles(ACK_LATENCY, waited, "early write ack");
    end
    release_req(c);
    model[a] = d;
    written.push_back(a);
  endtask

  task automatic read_word(input int c, input mem_addr_t a);
    int waited;
    start_access(c, 1'b0, a, '0);
    wait_ack(c, waited);
    if (waited < ACK_LATENCY) begin
      check_cycles(ACK_LATENCY, waited, "early read ack");
    end
    check_data(model[a], rdata[c*DW +: DW], $sformatf("client %0d read of %h", c, a));
    release_req(c);
  endtask

  function automatic mem_addr_t pick_written();
    return written[rand_bits(AW) % written.size()];
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_single_client();
    mem_addr_t a;
    mem_data_t d;
    int        waited;
    check_acks('0, ack);
    a = mem_addr_t'(rand_bits(AW));
    d = mem_data_t'(rand_bits(DW));
    start_access(0, 1'b1, a, d);
    wait_ack(0, waited);
    check_cycles(ACK_LATENCY, waited, "write ack latency");
    release_req(0);
    model[a] = d;
    written.push_back(a);
    start_access(0, 1'b0, a, '0);
    wait_ack(0, waited);
    check_cycles(ACK_LATENCY, waited, "read ack latency");
    check_data(model[a], rdata[0 +: DW], "client 0 read back");
    release_req(0);
  endtask

  task automatic test_sweep();
    for (int i = 0; i < 16; i++) begin
      write_word(i % NUM, mem_addr_t'(rand_bits(AW)), mem_data_t'(rand_bits(DW)));
    end
    for (int i = 0; i < 16; i++) begin
      read_word((i + 1) % NUM, pick_written());
    end
  endtask

  task automatic test_equal_ages();
    mem_addr_t base;
    mem_data_t d [NUM];
    base = mem_addr_t'(rand_bits(AW));
    for (int c = 0; c < NUM; c++) begin
      d[c] = mem_data_t'(rand_bits(DW));
    end
    ack_order.delete();
    fork
      write_word(0, base, d[0]);
      write_word(1, mem_addr_t'(base + 1), d[1]);
      write_word(2, mem_addr_t'(base + 2), d[2]);
      write_word(3, mem_addr_t'(base + 3), d[3]);
    join
    fork
      read_word(0, mem_addr_t'(base + 1));
      read_word(1, mem_addr_t'(base + 2));
      read_word(2, mem_addr_t'(base + 3));
      read_word(3, base);
    join
    for (int n = 0; n < 2 * NUM; n++) begin
      expect_grant(client_id_t'(n % NUM));
    end
    expect_no_more_grants();
  endtask

  task automatic test_staggered();
    mem_addr_t a0;
    int        waited;
    a0 = pick_written();
    ack_order.delete();
    start_access(0, 1'b0, a0, '0);
    wait_ack(0, waited);
    check_data(model[a0], rdata[0 +: DW], "client 0 held read");
    fork
      read_word(3, pick_written());
      begin
        @(negedge clk);
        read_word(1, pick_written());
      end
      begin
        repeat (2) @(negedge clk);
        read_word(2, pick_written());
      end
      begin
        // Client 0 keeps its access open until all three are queued
        repeat (4) @(negedge clk);
        release_req(0);
      end
    join
    expect_grant(0);
    expect_grant(3);
    expect_grant(1);
    expect_grant(2);
    expect_no_more_grants();
  endtask

  task automatic test_no_starvation();
    ack_order.delete();
    fork
      begin
        read_word(0, pick_written());
        read_word(0, pick_written());
      end
      read_word(1, pick_written());
      read_word(2, pick_written());
      read_word(3, pick_written());
    join
    for (int n = 0; n <= NUM; n++) begin
      expect_grant(client_id_t'(n % NUM));
    end
    expect_no_more_grants();
  endtask

  initial begin
    lfsr_state    = 32'h8725;
    cycle_count   = 0;
    data_errors   = 0;
    order_errors  = 0;
    ctrl_errors   = 0;
    assert_errors = 0;
    ack_prev      = '0;
    rst           = 1'b1;
    req           = '0;
    we            = '0;
    addr          = '0;
    wdata         = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    test_single_client();
    test_sweep();
    test_equal_ages();
    test_staggered();
    test_no_starvation();
    repeat (2) @(negedge clk);
    assert_errors = dut_i.u_arbiter.assert_i.failures;
    $display("Errors: data %0d, grant order %0d, control %0d, assertion %0d",
             data_errors, order_errors, ctrl_errors, assert_errors);
    if (data_errors + order_errors + ctrl_errors + assert_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/mem_share_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_share_defs.svh"

module mem_share_top (
  input  wire                                      clk,
  input  wire                                      rst,
  // Per client fields, packed with client 0 in the low slice
  input  wire  [`MS_NUM_CLIENTS-1:0]               req,
  input  wire  [`MS_NUM_CLIENTS-1:0]               we,
  input  wire  [`MS_NUM_CLIENTS*`MS_ADDR_WIDTH-1:0] addr,
  input  wire  [`MS_NUM_CLIENTS*`MS_DATA_WIDTH-1:0] wdata,
  output wire  [`MS_NUM_CLIENTS-1:0]               ack,
  output wire  [`MS_NUM_CLIENTS*`MS_DATA_WIDTH-1:0] rdata
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbiter to RAM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  ram_if ram_bus ();

  age_arbiter u_arbiter (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .ram   (ram_bus.master)
  );

  shared_ram u_ram (
    .clk (clk),
    .ram (ram_bus.slave)
  );

endmodule

`default_nettype wire

/* verilog/shared_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module shared_ram
  import mem_share_pkg::*;
(
  input wire    clk,
  ram_if.slave  ram
);

  localparam int DEPTH = 2 ** $bits(mem_addr_t);

  mem_data_t mem [DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Single port, one edge of read latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (ram.en) begin
      if (ram.we) begin
        mem[ram.addr] <= ram.wdata;
      end else begin
        // Held until the next read
        ram.rdata <= mem[ram.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/mem_share_pkg.sv
common/ram_if.sv
arbiter/max_finder_tree.sv
arbiter/age_arbiter.sv
verilog/shared_ram.sv
verilog/mem_share_top.sv
tb/mem_share_assert.sv
tb/mem_share_tb.sv
